// File: Makefile
# Verilator build and run for the scalar integer divider

SRCS := verilog.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
SIM  := obj_dir/Vscalar_integer_divider_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module scalar_integer_divider_tb -f verilog.f

# Fails on a nonzero exit or on the fail message in the log
run: $(SIM)
	./$(SIM) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "Result: FAILED" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verification/scalar_integer_divider_tb.sv
`include "divider_consts.svh"

module scalar_integer_divider_tb;

  import arith_pkg::*;

  localparam int W = `DIVIDER_DATA_SIZE;
  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 8;
  // Operations of the test sequence
  localparam int NUM_UNSIGNED = 40;
  localparam int NUM_SIGNED = 40;
  localparam int NUM_DIRECTED = 11;
  // Issued operations, each costing at most W + 6 cycles
  localparam int OP_BUDGET = NUM_UNSIGNED + NUM_SIGNED + NUM_DIRECTED;
  localparam int WATCHDOG_CYCLES = OP_BUDGET * (W + 6) + RESET_CYCLES + 4 * W + 100;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic        CLK;
  logic        RST;
  logic        START;
  logic [W-1:0] DIVIDEND;
  logic [W-1:0] DIVISOR;
  sign_mode_t  SIGNED_MODE;
  logic        READY;
  logic        BUSY;
  logic [W-1:0] QUOTIENT;
  logic [W-1:0] REMAINDER;
  div_status_t STATUS;

  integer seed;
  int     cycle_count;
  int     value_errors;
  int     protocol_errors;
  int     ops_issued;
  int     ready_count;

  // Expected results, pushed when the model accepts a START
  logic [W-1:0] exp_quo[$];
  logic [W-1:0] exp_rem[$];
  div_status_t  exp_stat[$];

  scalar_integer_divider scalar_integer_divider_inst (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .DIVIDEND    (DIVIDEND),
    .DIVISOR     (DIVISOR),
    .SIGNED_MODE (SIGNED_MODE),
    .READY       (READY),
    .BUSY        (BUSY),
    .QUOTIENT    (QUOTIENT),
    .REMAINDER   (REMAINDER),
    .STATUS      (STATUS)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock, cycle count and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the divider tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Magnitudes divided by the simulator, signs applied afterwards
  function automatic void reference_divide(
    input  logic [W-1:0] dividend,
    input  logic [W-1:0] divisor,
    input  sign_mode_t   mode,
    output logic [W-1:0] quo,
    output logic [W-1:0] rem,
    output div_status_t  stat
  );
    logic         a_neg;
    logic         b_neg;
    logic [W-1:0] a_mag;
    logic [W-1:0] b_mag;
    logic [W-1:0] q_mag;
    logic [W-1:0] r_mag;
    a_neg = (mode == SIGN_SIGNED) && dividend[W-1];
    b_neg = (mode == SIGN_SIGNED) && divisor[W-1];
    a_mag = a_neg ? -dividend : dividend;
    b_mag = b_neg ? -divisor : divisor;
    stat.div_by_zero = (divisor == '0);
    stat.overflow = (mode == SIGN_SIGNED) && (dividend == MOST_NEG) && (divisor == '1);
    if (divisor == '0) begin
      // All ones and the dividend untouched
      quo = '1;
      rem = dividend;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
      quo = (a_neg ^ b_neg) ? -q_mag : q_mag;
      rem = a_neg ? -r_mag : r_mag;
    end
  endfunction

  task automatic compare_word(input string name, input logic [W-1:0] expected,
                              input logic [W-1:0] actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checker, sampled at falling edges
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare_results
    logic         pending;
    logic         op_active;
    logic         accept;
    int           accept_cycle;
    logic [W-1:0] q;
    logic [W-1:0] r;
    div_status_t  s;
    pending = 1'b0;
    op_active = 1'b0;
    accept_cycle = 0;
    forever begin
      @(negedge CLK);
      if (!RST) begin
        // Accepted START was sampled at the edge just passed
        if (pending) begin
          op_active = 1'b1;
          pending = 1'b0;
        end
        accept = START && !op_active;
        compare_word("BUSY", W'(op_active), W'(BUSY));
        if (READY) begin
          if (!op_active || exp_quo.size() == 0) begin
            protocol_errors++;
            $display("READY pulsed at %0t with no operation in flight", $time);
          end else begin
            compare_word("READY latency", W'(W + 2), W'(cycle_count - accept_cycle));
            compare_word("QUOTIENT", exp_quo.pop_front(), QUOTIENT);
            compare_word("REMAINDER", exp_rem.pop_front(), REMAINDER);
            compare_word("STATUS", W'(exp_stat.pop_front()), W'(STATUS));
            ready_count++;
          end
          op_active = 1'b0;
        end
        if (accept) begin
          pending = 1'b1;
          accept_cycle = cycle_count + 1;
          reference_divide(DIVIDEND, DIVISOR, SIGNED_MODE, q, r, s);
          exp_quo.push_back(q);
          exp_rem.push_back(r);
          exp_stat.push_back(s);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_idle();
    @(negedge CLK);
    while (BUSY) @(negedge CLK);
  endtask

  // One-cycle START strobe with operands
  task automatic issue_op(input logic [W-1:0] a, input logic [W-1:0] b,
                          input sign_mode_t mode);
    wait_idle();
    @(posedge CLK);
    START <= 1'b1;
    DIVIDEND <= a;
    DIVISOR <= b;
    SIGNED_MODE <= mode;
    @(posedge CLK);
    START <= 1'b0;
    ops_issued++;
  endtask

  // Second START while busy, which the unit drops
  task automatic issue_op_with_intrusion(input logic [W-1:0] a, input logic [W-1:0] b,
                                         input sign_mode_t mode, input int delay);
    issue_op(a, b, mode);
    repeat (delay) @(posedge CLK);
    START <= 1'b1;
    DIVIDEND <= ~a;
    DIVISOR <= b + 1'b1;
    SIGNED_MODE <= mode;
    @(posedge CLK);
    START <= 1'b0;
  endtask

  // Random operand narrowed by a random shift so quotients vary in size
  task automatic random_operand(output logic [W-1:0] value);
    int unsigned shift_amt;
    value = W'($random(seed));
    shift_amt = $unsigned($random(seed)) % W;
    value = value >> shift_amt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    seed = 32'h3e3f_0237;
    cycle_count = 0;
    value_errors = 0;
    protocol_errors = 0;
    ops_issued = 0;
    ready_count = 0;
    RST = 1'b1;
    START = 1'b0;
    DIVIDEND = '0;
    DIVISOR = '0;
    SIGNED_MODE = SIGN_UNSIGNED;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;

    // Outputs cleared by reset
    @(negedge CLK);
    compare_word("READY", '0, W'(READY));
    compare_word("QUOTIENT", '0, QUOTIENT);
    compare_word("REMAINDER", '0, REMAINDER);
    compare_word("STATUS", '0, W'(STATUS));

    // Unsigned, nonzero divisors
    for (int i = 0; i < NUM_UNSIGNED; i++) begin
      random_operand(a);
      random_operand(b);
      if (b == '0) b = 1;
      issue_op(a, b, SIGN_UNSIGNED);
    end

    // Signed, all four sign combinations in turn
    for (int i = 0; i < NUM_SIGNED; i++) begin
      random_operand(a);
      random_operand(b);
      a = a >> 1;
      b = b >> 1;
      if (b == '0) b = 1;
      if (i % 4 >= 2) a = -a;
      if (i % 2 == 1) b = -b;
      issue_op(a, b, SIGN_SIGNED);
    end
    issue_op(-W'(7), W'(2), SIGN_SIGNED);
    issue_op(W'(7), -W'(2), SIGN_SIGNED);
    issue_op(-W'(7), -W'(2), SIGN_SIGNED);

    // Division by zero in both modes
    issue_op(W'($random(seed)), '0, SIGN_UNSIGNED);
    issue_op(MOST_NEG | W'(5), '0, SIGN_UNSIGNED);
    issue_op(W'(1234), '0, SIGN_SIGNED);
    issue_op(-W'(99), '0, SIGN_SIGNED);

    // Most negative by minus one
    issue_op(MOST_NEG, '1, SIGN_SIGNED);
    issue_op(MOST_NEG, '1, SIGN_UNSIGNED);

    // START during iterate and during the READY cycle
    issue_op_with_intrusion(W'(1000), W'(7), SIGN_UNSIGNED, 5);
    issue_op_with_intrusion(-W'(500), W'(9), SIGN_SIGNED, W + 2);

    // Room for any stray READY to show up
    wait_idle();
    repeat (W + 4) @(negedge CLK);

    assert (ready_count == ops_issued && exp_quo.size() == 0) else begin
      protocol_errors++;
      $display("Operation count mismatch: %0d issued, %0d READY pulses seen",
               ops_issued, ready_count);
    end

    $display("Checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/arith_pkg.sv
verilog/divider_ctrl_pkg.sv
verilog/divider_sequencer.sv
verilog/step_counter.sv
verilog/restoring_datapath.sv
verilog/scalar_integer_divider.sv
verification/scalar_integer_divider_tb.sv

// File: verilog/arith_pkg.sv
package arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand interpretation
  ////////////////////////////////////////////////////////////////////////////

  // How dividend and divisor bits are read
  typedef enum logic {
    SIGN_UNSIGNED = 1'b0,
    SIGN_SIGNED   = 1'b1
  } sign_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Result flags
  ////////////////////////////////////////////////////////////////////////////

  // Divide status, valid together with the result
  typedef struct packed {
    logic div_by_zero;
    // Most negative by minus one in signed mode
    logic overflow;
  } div_status_t;

endpackage

// File: verilog/divider_consts.svh
`ifndef DIVIDER_CONSTS_SVH
`define DIVIDER_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Divider sizing
////////////////////////////////////////////////////////////////////////////

// Default operand width in bits
`define DIVIDER_DATA_SIZE 32

// Step counter width for the default operand width
// 32 steps need the values 31 down to 0, one spare bit for headroom
`define DIVIDER_COUNT_SIZE 6

`endif

// File: verilog/divider_ctrl_pkg.sv
package divider_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////////////////////////////////////////

  // Idle waits for START
  // Iterate runs one shift-subtract per clock
  // Fixup applies signs and special cases
  // Done presents READY for one cycle
  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'b00,
    SEQ_ITERATE = 2'b01,
    SEQ_FIXUP   = 2'b10,
    SEQ_DONE    = 2'b11
  } seq_state_t;

endpackage

// File: verilog/divider_sequencer.sv
module divider_sequencer (
  input  logic CLK,
  input  logic RST,

  // Request side
  input  logic start,

  // From the step counter
  input  logic last,

  // Strobes to counter and datapath
  output logic load,
  output logic step,
  output logic fixup,

  // Handshake back to the requester
  output logic READY,
  output logic BUSY
);

  import divider_ctrl_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;

  // Load cycle marker, first cycle of iterate
  logic       load_q;

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= SEQ_IDLE;
      load_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      load_q  <= (state_q == SEQ_IDLE) && start;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // START outside idle is simply not looked at
      SEQ_IDLE: begin
        if (start) begin
          state_d = SEQ_ITERATE;
        end
      end
      // Counter flags the final step
      SEQ_ITERATE: begin
        if (last) begin
          state_d = SEQ_FIXUP;
        end
      end
      SEQ_FIXUP: begin
        state_d = SEQ_DONE;
      end
      SEQ_DONE: begin
        state_d = SEQ_IDLE;
      end
      default: begin
        state_d = SEQ_IDLE;
      end
    endcase
  end

  // Load cycle comes first after leaving idle, steps follow it
  assign load  = load_q;
  assign step  = (state_q == SEQ_ITERATE) && !load_q;
  assign fixup = (state_q == SEQ_FIXUP);

  // Results land in the datapath at the end of fixup
  assign READY = (state_q == SEQ_DONE);
  assign BUSY  = (state_q != SEQ_IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // A new operation only begins from a START seen in idle
  assert property (@(posedge CLK) disable iff (RST)
    $rose(BUSY) |-> $past(start));

  // Counter and sequencer agree on where the iteration ends
  assert property (@(posedge CLK) disable iff (RST)
    last |-> (state_q == SEQ_ITERATE));

  // No back-pressure, so a START during an operation is dropped
  assert property (@(posedge CLK) disable iff (RST)
    !(start && BUSY))
    else $warning("divider: START ignored while BUSY");

endmodule

// File: verilog/restoring_datapath.sv
`include "divider_consts.svh"

module restoring_datapath #(
  parameter int DATA_SIZE = `DIVIDER_DATA_SIZE
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Strobes from the sequencer
  input  logic                    load,
  input  logic                    step,
  input  logic                    fixup,

  // Operands, valid with load
  input  logic [DATA_SIZE-1:0]    dividend,
  input  logic [DATA_SIZE-1:0]    divisor,
  input  arith_pkg::sign_mode_t   signed_mode,

  // Results, held until the next fixup
  output logic [DATA_SIZE-1:0]    quotient,
  output logic [DATA_SIZE-1:0]    remainder,
  output arith_pkg::div_status_t  status
);

  import arith_pkg::*;

  // Operand signs and magnitudes at load
  logic                 dividend_neg;
  logic                 divisor_neg;
  logic [DATA_SIZE-1:0] dividend_abs;
  logic [DATA_SIZE-1:0] divisor_abs;
  logic                 min_by_minus_one;

  // Working registers
  logic [DATA_SIZE-1:0] divisor_mag_q;
  logic [DATA_SIZE-1:0] rem_q;
  logic [DATA_SIZE-1:0] quo_q;
  logic                 neg_quotient_q;
  logic                 neg_remainder_q;
  logic                 zero_divisor_q;
  logic                 overflow_q;

  // One restoring step
  logic [DATA_SIZE:0]   shifted;
  logic [DATA_SIZE:0]   trial;

  // Fixed-up results
  logic [DATA_SIZE-1:0] quo_fixed;
  logic [DATA_SIZE-1:0] rem_fixed;
  div_status_t          status_d;

  ////////////////////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////////////////////

  // Sign bits count only in signed mode
  assign dividend_neg = (signed_mode == SIGN_SIGNED) && dividend[DATA_SIZE-1];
  assign divisor_neg  = (signed_mode == SIGN_SIGNED) && divisor[DATA_SIZE-1];

  // Magnitude of the most negative value still fits unsigned
  assign dividend_abs = dividend_neg ? -dividend : dividend;
  assign divisor_abs  = divisor_neg ? -divisor : divisor;

  assign min_by_minus_one = (signed_mode == SIGN_SIGNED) &&
                            (dividend == {1'b1, {(DATA_SIZE-1){1'b0}}}) &&
                            (divisor == '1);

  ////////////////////////////////////////////////////////////////////////////
  // Shift-subtract
  ////////////////////////////////////////////////////////////////////////////

  // Next dividend bit enters the partial remainder from the quotient side
  assign shifted = {rem_q, quo_q[DATA_SIZE-1]};
  assign trial   = shifted - {1'b0, divisor_mag_q};

  always_ff @(posedge CLK) begin
    if (load) begin
      rem_q           <= '0;
      quo_q           <= dividend_abs;
      divisor_mag_q   <= divisor_abs;
      // Quotient negative on differing signs, remainder follows the dividend
      neg_quotient_q  <= dividend_neg ^ divisor_neg;
      neg_remainder_q <= dividend_neg;
      zero_divisor_q  <= (divisor == '0);
      overflow_q      <= min_by_minus_one;
    end else if (step) begin
      if (!trial[DATA_SIZE]) begin
        // Divisor fits, keep the difference
        rem_q <= trial[DATA_SIZE-1:0];
        quo_q <= {quo_q[DATA_SIZE-2:0], 1'b1};
      end else begin
        // Restore
        rem_q <= shifted[DATA_SIZE-1:0];
        quo_q <= {quo_q[DATA_SIZE-2:0], 1'b0};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sign and zero fixup
  ////////////////////////////////////////////////////////////////////////////

  // With a zero divisor every step shifts, so rem_q ends as the dividend magnitude
  // and the sign correction alone gives back the dividend
  assign quo_fixed = zero_divisor_q ? '1 :
                     (neg_quotient_q ? -quo_q : quo_q);
  assign rem_fixed = neg_remainder_q ? -rem_q : rem_q;

  // Most negative by minus one needs no special case, only the flag
  assign status_d.div_by_zero = zero_divisor_q;
  assign status_d.overflow    = overflow_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      quotient  <= '0;
      remainder <= '0;
      status    <= '0;
    end else if (fixup) begin
      quotient  <= quo_fixed;
      remainder <= rem_fixed;
      status    <= status_d;
    end
  end

  // Fixup only ever follows the last step
  assert property (@(posedge CLK) disable iff (RST)
    !(fixup && step));

endmodule

// File: verilog/scalar_integer_divider.sv
`include "divider_consts.svh"

module scalar_integer_divider #(
  parameter int DATA_SIZE = `DIVIDER_DATA_SIZE
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Request
  input  logic                    START,
  input  logic [DATA_SIZE-1:0]    DIVIDEND,
  input  logic [DATA_SIZE-1:0]    DIVISOR,
  input  arith_pkg::sign_mode_t   SIGNED_MODE,

  // Response
  output logic                    READY,
  output logic                    BUSY,
  output logic [DATA_SIZE-1:0]    QUOTIENT,
  output logic [DATA_SIZE-1:0]    REMAINDER,
  output arith_pkg::div_status_t  STATUS
);

  // Sequencer strobes
  logic load;
  logic step;
  logic fixup;

  // Final step marker from the counter
  logic last;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  divider_sequencer divider_sequencer_inst (
    .CLK   (CLK),
    .RST   (RST),
    .start (START),
    .last  (last),
    .load  (load),
    .step  (step),
    .fixup (fixup),
    .READY (READY),
    .BUSY  (BUSY)
  );

  step_counter #(
    .DATA_SIZE (DATA_SIZE)
  ) step_counter_inst (
    .CLK  (CLK),
    .RST  (RST),
    .load (load),
    .step (step),
    .last (last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////////////////////

  restoring_datapath #(
    .DATA_SIZE (DATA_SIZE)
  ) restoring_datapath_inst (
    .CLK         (CLK),
    .RST         (RST),
    .load        (load),
    .step        (step),
    .fixup       (fixup),
    .dividend    (DIVIDEND),
    .divisor     (DIVISOR),
    .signed_mode (SIGNED_MODE),
    .quotient    (QUOTIENT),
    .remainder   (REMAINDER),
    .status      (STATUS)
  );

endmodule

// File: verilog/step_counter.sv
`include "divider_consts.svh"

module step_counter #(
  parameter int DATA_SIZE = `DIVIDER_DATA_SIZE
) (
  input  logic CLK,
  input  logic RST,

  // Strobes from the sequencer
  input  logic load,
  input  logic step,

  // High during the final step
  output logic last
);

  // Room for DATA_SIZE - 1 down to zero
  localparam int COUNT_SIZE = $clog2(DATA_SIZE + 1);

  logic [COUNT_SIZE-1:0] count_q;

  ////////////////////////////////////////////////////////////////////////////
  // Remaining steps
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count_q <= '0;
    end else if (load) begin
      // One step per operand bit
      count_q <= COUNT_SIZE'(DATA_SIZE - 1);
    end else if (step) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Zero count marks the step in progress as the final one
  assign last = step && (count_q == '0);

  // The final step is never followed by another one
  assert property (@(posedge CLK) disable iff (RST)
    last |=> !step);

endmodule
